/* verif/execPortInput.txt */
# valid fu op srcA srcB tag sqN brTaken brSqN expected killed (all hex)
# fu 0 = ALU, 1 = divider; killed 1 means the result must never appear
1 0 0 00000005 00000007 01 01 0 00 0000000C 0
1 0 1 00000003 00000005 02 02 0 00 FFFFFFFE 0
1 0 2 F0F0F0F0 0FF00FF0 03 03 0 00 00F000F0 0
1 0 3 F0000000 0000000F 04 04 0 00 F000000F 0
1 0 4 AAAAAAAA FFFFFFFF 05 05 0 00 55555555 0
1 0 5 00000001 00000024 06 06 0 00 00000010 0
1 0 6 80000000 0000001F 07 07 0 00 00000001 0
1 0 7 80000000 00000004 08 08 0 00 F8000000 0
1 0 8 FFFFFFFF 00000001 09 09 0 00 00000001 0
1 0 9 FFFFFFFF 00000001 0A 0A 0 00 00000000 0
1 0 0 00000010 00000020 4B 0B 0 00 00000030 0
1 1 0 FFFFFFF9 00000002 0C 0C 0 00 FFFFFFFD 0
1 0 0 00000001 00000001 0D 0D 0 00 00000002 0
1 0 0 00000002 00000002 0E 0E 0 00 00000004 0
1 1 2 FFFFFFF9 00000002 0F 0F 0 00 FFFFFFFF 0
1 1 1 00000064 00000007 10 10 0 00 0000000E 0
1 1 3 00000064 00000007 11 11 0 00 00000002 0
1 1 0 00001234 00000000 12 12 0 00 FFFFFFFF 0
1 1 2 00001234 00000000 13 13 0 00 00001234 0
1 1 0 80000000 FFFFFFFF 14 14 0 00 80000000 0
1 1 2 80000000 FFFFFFFF 15 15 0 00 00000000 0
1 1 1 00000009 00000003 56 16 0 00 00000003 0
1 1 0 00000064 00000005 17 30 0 00 00000014 1
1 0 0 00000001 00000001 18 20 1 2F 00000002 0
1 0 0 00000001 00000002 19 35 1 34 00000003 1
1 1 1 00000008 00000002 1A 36 1 35 00000004 1
1 0 0 00000003 00000003 1B 40 0 00 00000006 1
0 0 0 00000000 00000000 00 00 1 3F 00000000 0
1 0 0 00000004 00000004 1C 42 0 00 00000008 1
0 0 0 00000000 00000000 00 00 0 00 00000000 0
0 0 0 00000000 00000000 00 00 1 41 00000000 0
1 0 0 00000007 00000001 1D 43 0 00 00000008 0

/* execPort.f */
source/execPkg.sv
source/intAlu.sv
source/divControl.sv
source/divStepCounter.sv
source/divDatapath.sv
source/resultBus.sv
source/execPort.sv
verif/clockGen.sv
verif/execPortTb.sv

/* Bender.yml */
package:
  name: execPort

sources:
  - source/execPkg.sv
  - source/intAlu.sv
  - source/divControl.sv
  - source/divStepCounter.sv
  - source/divDatapath.sv
  - source/resultBus.sv
  - source/execPort.sv
  - target: test
    files:
      - verif/clockGen.sv
      - verif/execPortTb.sv

/* verif/execPortTb.sv */
`timescale 1ns/1ps
`default_nettype none

module execPortTb;
    import execPkg::*;

    logic     clk;
    logic     reset;
    ExUop     issue;
    BranchInv branch;
    ResUop    wb;
    logic     wbHasResult;
    logic     divDoNotIssue;

    ResUop       expMap[int];                       // Scoreboard keyed by tag
    int          issueCycle[int];
    bit          isAlu[int];
    int          cycle;
    logic [15:0] lfsr;
    bit          divBusy;                           // Expected divide not yet written back
    int          divHoldCycle;

    clockGen i_clockGen (
        .clk   (clk),
        .reset (reset)
    );

    execPort i_dut (
        .clk           (clk),
        .reset         (reset),
        .issue         (issue),
        .branch        (branch),
        .wb            (wb),
        .wbHasResult   (wbHasResult),
        .divDoNotIssue (divDoNotIssue)
    );

    always @(posedge clk) cycle <= cycle + 1;

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic compareRes(input string name, input ResUop got, input ResUop exp);
        if (got !== exp) begin
            failNow($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failNow($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // Galois LFSR, one step per bit taken
    task automatic takeBit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
    endtask

    task automatic runLine(input logic [31:0] f[11]);
        ExUop  u;
        ResUop e;
        logic  b0, b1;
        int    waited;
        if (f[0][0]) begin
            takeBit(b0);
            takeBit(b1);
            for (int i = 0; i < {b1, b0}; i++) begin
                @(posedge clk);
                issue.valid  <= 1'b0;
                branch.taken <= 1'b0;
            end
        end
        if (f[0][0] && f[1][0]) begin               // Divider must be free
            waited = 0;
            @(negedge clk);
            while (divDoNotIssue) begin
                waited++;
                if (waited > 200) failNow("Divider stayed busy for too long");
                @(posedge clk);
                issue.valid  <= 1'b0;
                branch.taken <= 1'b0;
                @(negedge clk);
            end
        end
        if (f[0][0] && !f[1][0] && divBusy) begin   // Meet the divider in its hold cycle
            waited = 0;
            @(negedge clk);
            while (cycle < divHoldCycle) begin
                waited++;
                if (waited > 200) failNow("ALU issue never lined up with the divider result");
                @(posedge clk);
                issue.valid  <= 1'b0;
                branch.taken <= 1'b0;
                @(negedge clk);
            end
        end
        u.valid  = f[0][0];
        u.fu     = FuType'(f[1][0]);
        u.op     = OpCode'(f[2][3:0]);
        u.srcA   = f[3];
        u.srcB   = f[4];
        u.tagDst = Tag'(f[5]);
        u.sqN    = SqN'(f[6]);
        @(posedge clk);
        issue         <= u;
        branch.taken  <= f[7][0];
        branch.sqN    <= SqN'(f[8]);
        if (f[0][0] && !f[10][0]) begin
            e.valid          = 1'b1;
            e.result         = f[9];
            e.tagDst         = u.tagDst;
            e.sqN            = u.sqN;
            expMap[f[5]]     = e;
            isAlu[f[5]]      = !f[1][0];
            issueCycle[f[5]] = cycle + 1;
            if (f[1][0]) begin
                divHoldCycle = issueCycle[f[5]] + divSteps - 1;
                @(posedge clk);
                issue.valid  <= 1'b0;
                branch.taken <= 1'b0;
                @(negedge clk);
                compareBit("divDoNotIssue", divDoNotIssue, 1'b1);
                divBusy = 1'b1;
            end
        end
    endtask

    // ------------------------------
    // Writeback monitor
    // ------------------------------
    always @(negedge clk) begin : monitor
        int key;
        if (reset === 1'b0) begin
            if (wb.valid) begin
                key = int'(wb.tagDst);
                if (!expMap.exists(key)) begin
                    failNow($sformatf("Unexpected writeback with tag %h", wb.tagDst));
                end
                compareRes("wb", wb, expMap[key]);
                compareBit("wbHasResult", wbHasResult, !expMap[key].tagDst[tagNoRegBit]);
                if (isAlu[key] && cycle - issueCycle[key] != 2) begin
                    failNow($sformatf("[FAIL] %0t aluLatency got %0d expected 2",
                                      $time, cycle - issueCycle[key]));
                end
                if (!isAlu[key]) begin
                    divBusy = 1'b0;
                end
                expMap.delete(key);
            end else begin
                compareBit("wbHasResult", wbHasResult, 1'b0);
            end
            if (divBusy) begin
                compareBit("divDoNotIssue", divDoNotIssue, 1'b1);
            end
        end
    end

    initial begin : driver
        int          fd;
        int          nItems;
        int          waited;
        string       line;
        logic [31:0] f[11];
        issue        = '0;
        branch       = '0;
        cycle        = 0;
        lfsr         = 16'd2340;
        divBusy      = 1'b0;
        divHoldCycle = 0;
        waited       = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 20) failNow("Reset never went low");
        end while (reset !== 1'b0);
        compareBit("wb.valid", wb.valid, 1'b0);
        compareBit("wbHasResult", wbHasResult, 1'b0);
        compareBit("divDoNotIssue", divDoNotIssue, 1'b0);
        fd = $fopen("verif/execPortInput.txt", "r");
        if (fd == 0) failNow("Could not open verif/execPortInput.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            nItems = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                             f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (nItems != 11) failNow($sformatf("Malformed input line: %s", line));
            runLine(f);
        end
        $fclose(fd);
        @(posedge clk);
        issue.valid  <= 1'b0;
        branch.taken <= 1'b0;
        waited = 0;
        while (expMap.size() > 0) begin             // Drain the scoreboard
            @(negedge clk);
            waited++;
            if (waited > 500) failNow("Expected results never reached the writeback bus");
        end
        repeat (10) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);
    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    initial begin
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* source/execPort.sv */
`timescale 1ns/1ps
`default_nettype none

module execPort (
    input  wire                        clk,
    input  wire                        reset,
    input  wire execPkg::ExUop         issue,
    input  wire execPkg::BranchInv     branch,
    output execPkg::ResUop             wb,
    output logic                       wbHasResult,
    output logic                       divDoNotIssue
);
    import execPkg::*;

    ResUop aluRes;
    ResUop divRes;
    logic  divGrant;
    logic  startDiv, stepEn, divDone, divKill;
    logic  cntClear, lastStep;

    intAlu i_intAlu (
        .clk    (clk),
        .reset  (reset),
        .issue  (issue),
        .branch (branch),
        .aluRes (aluRes)
    );

    // ------------------------------
    // Divider
    // ------------------------------
    divControl i_divControl (
        .clk           (clk),
        .reset         (reset),
        .issue         (issue),
        .branch        (branch),
        .lastStep      (lastStep),
        .divGrant      (divGrant),
        .startDiv      (startDiv),
        .stepEn        (stepEn),
        .divDone       (divDone),
        .divKill       (divKill),
        .cntClear      (cntClear),
        .divDoNotIssue (divDoNotIssue)
    );

    divStepCounter i_divStepCounter (
        .clk      (clk),
        .reset    (reset),
        .cntClear (cntClear),
        .stepEn   (stepEn),
        .lastStep (lastStep)
    );

    divDatapath i_divDatapath (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .startDiv (startDiv),
        .stepEn   (stepEn),
        .divDone  (divDone),
        .divKill  (divKill),
        .divRes   (divRes)
    );

    resultBus i_resultBus (
        .clk         (clk),
        .reset       (reset),
        .aluRes      (aluRes),
        .divRes      (divRes),
        .branch      (branch),
        .wb          (wb),
        .wbHasResult (wbHasResult),
        .divGrant    (divGrant)
    );

endmodule

`default_nettype wire

/* source/resultBus.sv */
`timescale 1ns/1ps
`default_nettype none

module resultBus (
    input  wire                        clk,
    input  wire                        reset,
    input  wire execPkg::ResUop        aluRes,
    input  wire execPkg::ResUop        divRes,
    input  wire execPkg::BranchInv     branch,
    output execPkg::ResUop             wb,
    output logic                       wbHasResult,
    output logic                       divGrant
);
    import execPkg::*;

    ResUop winner;
    ResUop wbReg;
    logic  wbKill;

    // ALU first, divider waits in hold
    always_comb begin
        winner   = aluRes.valid ? aluRes : divRes;
        divGrant = divRes.valid && !aluRes.valid;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbReg.valid <= 1'b0;
        end else begin
            wbReg <= winner;
        end
    end

    assign wbKill = branch.taken && isYounger(wbReg.sqN, branch.sqN);

    always_comb begin
        wb          = wbReg;
        wb.valid    = wbReg.valid && !wbKill;
        wbHasResult = wb.valid && !wbReg.tagDst[tagNoRegBit];
    end

endmodule

`default_nettype wire

/* source/divDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module divDatapath (
    input  wire                        clk,
    input  wire                        reset,
    input  wire execPkg::ExUop         issue,
    input  wire                        startDiv,
    input  wire                        stepEn,
    input  wire                        divDone,
    input  wire                        divKill,
    output execPkg::ResUop             divRes
);
    import execPkg::*;

    logic [dataWidth-1:0] quo;
    logic [dataWidth-1:0] rem;
    logic [dataWidth-1:0] divisor;
    logic [dataWidth-1:0] dividend;
    DivOp                 op;
    logic                 negQuot, negRem, byZero, overflow;
    Tag                   tagDst;
    SqN                   sqN;

    logic                 signedOp, aNeg, bNeg;
    logic [dataWidth:0]   partial;
    logic [dataWidth+1:0] diff;
    logic [dataWidth-1:0] quoFixed, remFixed;

    always_comb begin
        signedOp = issue.op.div == divDiv || issue.op.div == divRem;
        aNeg     = signedOp && issue.srcA[dataWidth-1];
        bNeg     = signedOp && issue.srcB[dataWidth-1];
        partial  = {rem, quo[dataWidth-1]};
        diff     = {1'b0, partial} - {2'b00, divisor};
    end

    // ------------------------------
    // Restoring shift-subtract
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            quo <= '0;
            rem <= '0;
        end else if (startDiv) begin
            quo <= aNeg ? -issue.srcA : issue.srcA;
            rem <= '0;
        end else if (stepEn) begin
            quo <= {quo[dataWidth-2:0], !diff[dataWidth+1]};
            rem <= diff[dataWidth+1] ? partial[dataWidth-1:0] : diff[dataWidth-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (startDiv) begin
            divisor  <= bNeg ? -issue.srcB : issue.srcB;
            dividend <= issue.srcA;
            op       <= issue.op.div;
            negQuot  <= aNeg ^ bNeg;
            negRem   <= aNeg;                        // Remainder takes the dividend sign
            byZero   <= issue.srcB == '0;
            overflow <= signedOp && issue.srcA == intMin && issue.srcB == '1;
            tagDst   <= issue.tagDst;
            sqN      <= issue.sqN;
        end
    end

    always_comb begin
        quoFixed = negQuot ? -quo : quo;
        remFixed = negRem ? -rem : rem;
        if (byZero) begin
            quoFixed = '1;
            remFixed = dividend;
        end else if (overflow) begin
            quoFixed = dividend;
            remFixed = '0;
        end
        divRes.valid  = divDone && !divKill;
        divRes.result = (op == divRem || op == divRemu) ? remFixed : quoFixed;
        divRes.tagDst = tagDst;
        divRes.sqN    = sqN;
    end

endmodule

`default_nettype wire

/* source/divStepCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module divStepCounter (
    input  wire  clk,
    input  wire  reset,
    input  wire  cntClear,
    input  wire  stepEn,
    output logic lastStep
);
    import execPkg::*;

    logic [stepCntWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (reset || cntClear) begin
            count <= '0;
        end else if (stepEn) begin
            count <= count + 1'b1;                   // Wraps after the final step
        end
    end

    assign lastStep = stepEn && count == stepCntWidth'(divSteps - 1);

endmodule

`default_nettype wire

/* source/divControl.sv */
`timescale 1ns/1ps
`default_nettype none

module divControl (
    input  wire                        clk,
    input  wire                        reset,
    input  wire execPkg::ExUop         issue,
    input  wire execPkg::BranchInv     branch,
    input  wire                        lastStep,
    input  wire                        divGrant,
    output logic                       startDiv,
    output logic                       stepEn,
    output logic                       divDone,
    output logic                       divKill,
    output logic                       cntClear,
    output logic                       divDoNotIssue
);
    import execPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stHold
    } DivState;

    DivState state;
    DivState stateNext;
    SqN      activeSqN;
    logic    newDiv;

    always_comb begin
        newDiv = issue.valid && issue.fu == fuDiv &&
                 !(branch.taken && isYounger(issue.sqN, branch.sqN));
        startDiv      = state == stIdle && newDiv;
        divKill       = state != stIdle && branch.taken && isYounger(activeSqN, branch.sqN);
        stepEn        = state == stRun;
        divDone       = state == stHold;             // Result stays on divRes here
        cntClear      = state == stIdle;
        divDoNotIssue = state != stIdle;
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        stateNext = state;
        unique case (state)
            stIdle:  if (startDiv) stateNext = stRun;
            stRun:   if (divKill) stateNext = stIdle;
                     else if (lastStep) stateNext = stHold;
            stHold:  if (divKill || divGrant) stateNext = stIdle;
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (startDiv) begin
            activeSqN <= issue.sqN;
        end
    end

endmodule

`default_nettype wire

/* source/intAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input  wire                        clk,
    input  wire                        reset,
    input  wire execPkg::ExUop         issue,
    input  wire execPkg::BranchInv     branch,
    output execPkg::ResUop             aluRes
);
    import execPkg::*;

    logic [dataWidth-1:0]  aluOut;
    logic [shamtWidth-1:0] shamt;
    logic                  takeUop;
    logic                  heldKill;
    ResUop                 aluReg;

    // ------------------------------
    // Operation decode
    // ------------------------------
    always_comb begin
        shamt = issue.srcB[shamtWidth-1:0];
        unique case (issue.op.alu)
            aluAdd:  aluOut = issue.srcA + issue.srcB;
            aluSub:  aluOut = issue.srcA - issue.srcB;
            aluAnd:  aluOut = issue.srcA & issue.srcB;
            aluOr:   aluOut = issue.srcA | issue.srcB;
            aluXor:  aluOut = issue.srcA ^ issue.srcB;
            aluSll:  aluOut = issue.srcA << shamt;
            aluSrl:  aluOut = issue.srcA >> shamt;
            aluSra:  aluOut = $signed(issue.srcA) >>> shamt;
            aluSlt:  aluOut = {{(dataWidth-1){1'b0}}, $signed(issue.srcA) < $signed(issue.srcB)};
            aluSltu: aluOut = {{(dataWidth-1){1'b0}}, issue.srcA < issue.srcB};
            default: aluOut = '0;
        endcase
    end

    // Entry check covers a branch arriving with the issue
    assign takeUop = issue.valid && issue.fu == fuInt &&
                     !(branch.taken && isYounger(issue.sqN, branch.sqN));

    always_ff @(posedge clk) begin
        if (reset) begin
            aluReg.valid <= 1'b0;
        end else begin
            aluReg.valid <= takeUop;
            if (takeUop) begin
                aluReg.result <= aluOut;
                aluReg.tagDst <= issue.tagDst;
                aluReg.sqN    <= issue.sqN;
            end
        end
    end

    assign heldKill = branch.taken && isYounger(aluReg.sqN, branch.sqN);

    always_comb begin
        aluRes       = aluReg;
        aluRes.valid = aluReg.valid && !heldKill;   // Drop while held in the output stage
    end

endmodule

`default_nettype wire

/* source/execPkg.sv */
`default_nettype none

package execPkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int dataWidth    = 32;
    localparam int sqnWidth     = 7;
    localparam int tagWidth     = 7;
    localparam int divSteps     = 32;
    localparam int tagNoRegBit  = 6;                    // Set means no register result
    localparam int shamtWidth   = $clog2(dataWidth);
    localparam int stepCntWidth = $clog2(divSteps);

    localparam logic [dataWidth-1:0] intMin = {1'b1, {(dataWidth-1){1'b0}}};

    typedef logic [sqnWidth-1:0] SqN;
    typedef logic [tagWidth-1:0] Tag;

    typedef enum logic {
        fuInt = 1'b0,
        fuDiv = 1'b1
    } FuType;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluSll, aluSrl, aluSra, aluSlt, aluSltu
    } AluOp;

    typedef enum logic [3:0] {
        divDiv, divDivu, divRem, divRemu
    } DivOp;

    // Meaning depends on the fu field of the uop
    typedef union packed {
        AluOp alu;
        DivOp div;
    } OpCode;

    typedef struct packed {
        logic                 valid;
        FuType                fu;
        OpCode                op;
        logic [dataWidth-1:0] srcA;
        logic [dataWidth-1:0] srcB;
        Tag                   tagDst;
        SqN                   sqN;
    } ExUop;

    typedef struct packed {
        logic                 valid;
        logic [dataWidth-1:0] result;
        Tag                   tagDst;
        SqN                   sqN;
    } ResUop;

    typedef struct packed {
        logic taken;
        SqN   sqN;
    } BranchInv;

    // True when a is younger than b, safe across counter wraparound
    function automatic logic isYounger(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire
